// File: hdl/dtlb_params.svh
`ifndef DTLB_PARAMS_SVH
`define DTLB_PARAMS_SVH

// Virtual page number split
`define DTLB_TAG_WIDTH  20
`define DTLB_IDX_WIDTH  3
`define DTLB_VPN_WIDTH  23

// Physical page number
`define DTLB_DATA_WIDTH 20

// Geometry
`define DTLB_WAYS       16
`define DTLB_WAY_WIDTH  4
`define DTLB_SETS       8

`endif

// File: hdl/dtlb_pkg.sv
`include "dtlb_params.svh"

package dtlb_pkg;

    // Virtual tag above the set index
    typedef logic [`DTLB_TAG_WIDTH-1:0]  tag_t;

    typedef logic [`DTLB_IDX_WIDTH-1:0]  idx_t;

    // Physical page number
    typedef logic [`DTLB_DATA_WIDTH-1:0] ppn_t;

    typedef logic [`DTLB_WAY_WIDTH-1:0]  way_t;

    // One bit per way
    typedef logic [`DTLB_WAYS-1:0]       way_vec_t;

endpackage

// File: hdl/dtlb_wb_front.sv
`timescale 1ns/1ns

`include "dtlb_params.svh"

module dtlb_wb_front import dtlb_pkg::*; (
    input  logic                       clk,
    input  logic                       i_rst,

    input  logic                       i_wb_cyc,
    input  logic                       i_wb_stb,
    input  logic                       i_wb_we,
    input  logic [`DTLB_VPN_WIDTH-1:0] i_wb_adr,
    input  ppn_t                       i_wb_dat,
    input  logic                       i_done,

    output logic                       o_req_valid,
    output logic                       o_req_we,
    output idx_t                       o_req_idx,
    output tag_t                       o_req_tag,
    output ppn_t                       o_req_dat
);

    logic busy;
    logic accept;

    // Held stb is ignored until the response cycle is over
    assign accept = i_wb_cyc & i_wb_stb & ~busy;

    always_ff @(posedge clk) begin
        if (i_rst) begin
            busy        <= 1'b0;
            o_req_valid <= 1'b0;
        end else begin
            o_req_valid <= accept;
            if (accept) begin
                busy <= 1'b1;
            end else if (i_done) begin
                busy <= 1'b0;
            end
        end
    end

    // Index in the low bits, tag above
    always_ff @(posedge clk) begin
        if (accept) begin
            o_req_we  <= i_wb_we;
            o_req_idx <= i_wb_adr[`DTLB_IDX_WIDTH-1:0];
            o_req_tag <= i_wb_adr[`DTLB_VPN_WIDTH-1:`DTLB_IDX_WIDTH];
            o_req_dat <= i_wb_dat;
        end
    end

endmodule

// File: hdl/dtlb_entry_array.sv
`timescale 1ns/1ns

`include "dtlb_params.svh"

module dtlb_entry_array import dtlb_pkg::*; (
    input  logic                  clk,
    input  logic                  i_rst,

    input  logic                  i_req_valid,
    input  logic                  i_req_we,
    input  idx_t                  i_req_idx,
    input  tag_t                  i_req_tag,
    input  ppn_t                  i_req_dat,

    input  logic                  i_wr_en,
    input  idx_t                  i_wr_idx,
    input  way_t                  i_wr_way,
    input  tag_t                  i_wr_tag,
    input  ppn_t                  i_wr_dat,

    output logic                  o_rd_valid,
    output logic                  o_rd_we,
    output idx_t                  o_rd_idx,
    output tag_t                  o_rd_tag,
    output ppn_t                  o_rd_dat,
    output way_vec_t              o_set_vld,
    output tag_t [`DTLB_WAYS-1:0] o_set_tags,
    output ppn_t [`DTLB_WAYS-1:0] o_set_data
);

    way_vec_t              vld_q    [`DTLB_SETS];
    tag_t [`DTLB_WAYS-1:0] tag_mem  [`DTLB_SETS];
    ppn_t [`DTLB_WAYS-1:0] data_mem [`DTLB_SETS];

    // Valid bits per set
    always_ff @(posedge clk) begin
        if (i_rst) begin
            for (int s = 0; s < `DTLB_SETS; s++) begin
                vld_q[s] <= '0;
            end
        end else if (i_wr_en) begin
            vld_q[i_wr_idx][i_wr_way] <= 1'b1;
        end
    end

    // Only the indexed set is written
    always_ff @(posedge clk) begin
        if (i_wr_en) begin
            tag_mem[i_wr_idx][i_wr_way]  <= i_wr_tag;
            data_mem[i_wr_idx][i_wr_way] <= i_wr_dat;
        end
    end

    always_ff @(posedge clk) begin
        if (i_rst) begin
            o_rd_valid <= 1'b0;
        end else begin
            o_rd_valid <= i_req_valid;
        end
    end

    // Registered set read, request fields ride along
    always_ff @(posedge clk) begin
        if (i_req_valid) begin
            o_rd_we    <= i_req_we;
            o_rd_idx   <= i_req_idx;
            o_rd_tag   <= i_req_tag;
            o_rd_dat   <= i_req_dat;
            o_set_vld  <= vld_q[i_req_idx];
            o_set_tags <= tag_mem[i_req_idx];
            o_set_data <= data_mem[i_req_idx];
        end
    end

endmodule

// File: hdl/dtlb_tag_match.sv
`timescale 1ns/1ns

`include "dtlb_params.svh"

module dtlb_tag_match import dtlb_pkg::*; (
    input  logic                  clk,
    input  logic                  i_rst,

    input  logic                  i_rd_valid,
    input  logic                  i_rd_we,
    input  idx_t                  i_rd_idx,
    input  tag_t                  i_rd_tag,
    input  ppn_t                  i_rd_dat,
    input  way_vec_t              i_set_vld,
    input  tag_t [`DTLB_WAYS-1:0] i_set_tags,
    input  ppn_t [`DTLB_WAYS-1:0] i_set_data,
    input  way_t                  i_victim_way,

    output logic                  o_wr_en,
    output idx_t                  o_wr_idx,
    output way_t                  o_wr_way,
    output tag_t                  o_wr_tag,
    output ppn_t                  o_wr_dat,
    output logic                  o_plru_touch,
    output way_t                  o_plru_way,
    output logic                  o_wb_ack,
    output logic                  o_wb_err,
    output ppn_t                  o_wb_dat,
    output logic                  o_done
);

    way_vec_t hit_vec;
    logic     hit;
    way_t     hit_way;
    way_t     free_way;
    way_t     fill_way;
    ppn_t     hit_data;
    logic     lookup_hit;

    // Entries are never duplicated, so at most one bit is set
    function automatic way_t onehot_to_way(way_vec_t vec);
        way_t way;
        way = '0;
        for (int w = 0; w < `DTLB_WAYS; w++) begin
            if (vec[w]) begin
                way = way | way_t'(w);
            end
        end
        return way;
    endfunction

    // Lowest way with a clear valid bit
    function automatic way_t find_free(way_vec_t vld);
        way_t way;
        way = '0;
        for (int w = `DTLB_WAYS - 1; w >= 0; w--) begin
            if (!vld[w]) begin
                way = way_t'(w);
            end
        end
        return way;
    endfunction

    always_comb begin
        for (int w = 0; w < `DTLB_WAYS; w++) begin
            hit_vec[w] = i_set_vld[w] & (i_set_tags[w] == i_rd_tag);
        end
    end

    assign hit      = |hit_vec;
    assign hit_way  = onehot_to_way(hit_vec);
    assign hit_data = i_set_data[hit_way];
    assign free_way = find_free(i_set_vld);

    // Existing tag first, then a free way, then the PLRU victim
    assign fill_way = hit           ? hit_way  :
                      ~&i_set_vld   ? free_way : i_victim_way;

    assign lookup_hit = i_rd_valid & ~i_rd_we & hit;

    assign o_wr_en  = i_rd_valid & i_rd_we;
    assign o_wr_idx = i_rd_idx;
    assign o_wr_way = fill_way;
    assign o_wr_tag = i_rd_tag;
    assign o_wr_dat = i_rd_dat;

    // On a lookup hit the fill way is the hit way
    assign o_plru_touch = o_wr_en | lookup_hit;
    assign o_plru_way   = fill_way;

    always_ff @(posedge clk) begin
        if (i_rst) begin
            o_wb_ack <= 1'b0;
            o_wb_err <= 1'b0;
        end else begin
            o_wb_ack <= o_wr_en | lookup_hit;
            o_wb_err <= i_rd_valid & ~i_rd_we & ~hit;
        end
    end

    // Zero on a miss and on a fill
    always_ff @(posedge clk) begin
        o_wb_dat <= lookup_hit ? hit_data : '0;
    end

    assign o_done = o_wb_ack | o_wb_err;

endmodule

// File: hdl/dtlb_plru_tree.sv
`timescale 1ns/1ns

`include "dtlb_params.svh"

module dtlb_plru_tree import dtlb_pkg::*; (
    input  logic clk,
    input  logic i_rst,

    input  logic i_touch,
    input  way_t i_touch_way,

    output way_t o_victim_way
);

    // Heap order, node n has children 2n+1 and 2n+2
    logic [`DTLB_WAYS-2:0] tree_q;
    logic [`DTLB_WAYS-2:0] tree_nxt;

    // 0 goes to the lower half, 1 to the upper
    always_comb begin : victim_walk
        int unsigned node;
        node = 0;
        for (int lvl = `DTLB_WAY_WIDTH - 1; lvl >= 0; lvl--) begin
            o_victim_way[lvl] = tree_q[node];
            node = 2 * node + 1 + int'(tree_q[node]);
        end
    end

    // Nodes on the touched path point away from it
    always_comb begin : touch_path
        int unsigned node;
        tree_nxt = tree_q;
        node     = 0;
        for (int lvl = `DTLB_WAY_WIDTH - 1; lvl >= 0; lvl--) begin
            tree_nxt[node] = ~i_touch_way[lvl];
            node = 2 * node + 1 + int'(i_touch_way[lvl]);
        end
    end

    always_ff @(posedge clk) begin
        if (i_rst) begin
            tree_q <= '0;
        end else if (i_touch) begin
            tree_q <= tree_nxt;
        end
    end

endmodule

// File: hdl/dtlb_top.sv
`timescale 1ns/1ns

`include "dtlb_params.svh"

module dtlb_top import dtlb_pkg::*; (
    input  logic                       clk,
    input  logic                       i_rst,

    input  logic                       i_wb_cyc,
    input  logic                       i_wb_stb,
    input  logic                       i_wb_we,
    input  logic [`DTLB_VPN_WIDTH-1:0] i_wb_adr,
    input  ppn_t                       i_wb_dat,
    output logic                       o_wb_ack,
    output logic                       o_wb_err,
    output ppn_t                       o_wb_dat
);

    // Front to array
    logic req_valid;
    logic req_we;
    idx_t req_idx;
    tag_t req_tag;
    ppn_t req_dat;

    // Array to match
    logic                     rd_valid;
    logic                     rd_we;
    idx_t                     rd_idx;
    tag_t                     rd_tag;
    ppn_t                     rd_dat;
    way_vec_t                 set_vld;
    tag_t [`DTLB_WAYS-1:0]    set_tags;
    ppn_t [`DTLB_WAYS-1:0]    set_data;

    // Match write-back and replacement
    logic wr_en;
    idx_t wr_idx;
    way_t wr_way;
    tag_t wr_tag;
    ppn_t wr_dat;
    logic plru_touch;
    way_t plru_way;
    way_t victim_way;
    logic done;

    dtlb_wb_front dtlb_wb_front_i (
        .clk         (clk),
        .i_rst       (i_rst),
        .i_wb_cyc    (i_wb_cyc),
        .i_wb_stb    (i_wb_stb),
        .i_wb_we     (i_wb_we),
        .i_wb_adr    (i_wb_adr),
        .i_wb_dat    (i_wb_dat),
        .i_done      (done),
        .o_req_valid (req_valid),
        .o_req_we    (req_we),
        .o_req_idx   (req_idx),
        .o_req_tag   (req_tag),
        .o_req_dat   (req_dat)
    );

    dtlb_entry_array dtlb_entry_array_i (
        .clk         (clk),
        .i_rst       (i_rst),
        .i_req_valid (req_valid),
        .i_req_we    (req_we),
        .i_req_idx   (req_idx),
        .i_req_tag   (req_tag),
        .i_req_dat   (req_dat),
        .i_wr_en     (wr_en),
        .i_wr_idx    (wr_idx),
        .i_wr_way    (wr_way),
        .i_wr_tag    (wr_tag),
        .i_wr_dat    (wr_dat),
        .o_rd_valid  (rd_valid),
        .o_rd_we     (rd_we),
        .o_rd_idx    (rd_idx),
        .o_rd_tag    (rd_tag),
        .o_rd_dat    (rd_dat),
        .o_set_vld   (set_vld),
        .o_set_tags  (set_tags),
        .o_set_data  (set_data)
    );

    dtlb_tag_match dtlb_tag_match_i (
        .clk          (clk),
        .i_rst        (i_rst),
        .i_rd_valid   (rd_valid),
        .i_rd_we      (rd_we),
        .i_rd_idx     (rd_idx),
        .i_rd_tag     (rd_tag),
        .i_rd_dat     (rd_dat),
        .i_set_vld    (set_vld),
        .i_set_tags   (set_tags),
        .i_set_data   (set_data),
        .i_victim_way (victim_way),
        .o_wr_en      (wr_en),
        .o_wr_idx     (wr_idx),
        .o_wr_way     (wr_way),
        .o_wr_tag     (wr_tag),
        .o_wr_dat     (wr_dat),
        .o_plru_touch (plru_touch),
        .o_plru_way   (plru_way),
        .o_wb_ack     (o_wb_ack),
        .o_wb_err     (o_wb_err),
        .o_wb_dat     (o_wb_dat),
        .o_done       (done)
    );

    dtlb_plru_tree dtlb_plru_tree_i (
        .clk          (clk),
        .i_rst        (i_rst),
        .i_touch      (plru_touch),
        .i_touch_way  (plru_way),
        .o_victim_way (victim_way)
    );

endmodule

// File: testbench/dtlb_chk.sv
`timescale 1ns/1ns

module dtlb_chk (
    input logic clk,
    input logic i_rst,
    input logic i_wb_cyc,
    input logic i_wb_stb,
    input logic i_wb_ack,
    input logic i_wb_err
);

    ack_err_exclusive: assert property (
        @(posedge clk) disable iff (i_rst) !(i_wb_ack && i_wb_err)
    ) else $error("ack and err high in the same cycle");

    // Single-cycle response
    resp_one_cycle: assert property (
        @(posedge clk) disable iff (i_rst) (i_wb_ack || i_wb_err) |=> !(i_wb_ack || i_wb_err)
    ) else $error("response held longer than one cycle");

    resp_in_cycle: assert property (
        @(posedge clk) disable iff (i_rst) (i_wb_ack || i_wb_err) |-> (i_wb_cyc && i_wb_stb)
    ) else $error("response outside an active bus cycle");

    // Registered outputs, so checked one edge later
    no_resp_in_reset: assert property (
        @(posedge clk) i_rst |=> !(i_wb_ack || i_wb_err)
    ) else $error("response while in reset");

endmodule

// File: testbench/dtlb_tb.sv
`timescale 1ns/1ns

`include "dtlb_params.svh"

module dtlb_tb import dtlb_pkg::*; ();

    localparam int TIMEOUT = 20;

    typedef struct {
        string name;
        bit    we;
        tag_t  tag;
        idx_t  idx;
        ppn_t  dat;
        bit    exp_err;
        int    way;
    } entry_t;

    logic                       clk;
    logic                       i_rst;
    logic                       i_wb_cyc;
    logic                       i_wb_stb;
    logic                       i_wb_we;
    logic [`DTLB_VPN_WIDTH-1:0] i_wb_adr;
    ppn_t                       i_wb_dat;
    logic                       o_wb_ack;
    logic                       o_wb_err;
    ppn_t                       o_wb_dat;

    // dat is fill data for a fill and expected data for a lookup
    entry_t      table_q[$];
    ppn_t        set5_dat[16];
    logic [14:0] plru;
    int          errors;
    int          checks;

    dtlb_top dtlb_top_i (
        .clk      (clk),
        .i_rst    (i_rst),
        .i_wb_cyc (i_wb_cyc),
        .i_wb_stb (i_wb_stb),
        .i_wb_we  (i_wb_we),
        .i_wb_adr (i_wb_adr),
        .i_wb_dat (i_wb_dat),
        .o_wb_ack (o_wb_ack),
        .o_wb_err (o_wb_err),
        .o_wb_dat (o_wb_dat)
    );

    bind dtlb_top dtlb_chk dtlb_chk_i (
        .clk      (clk),
        .i_rst    (i_rst),
        .i_wb_cyc (i_wb_cyc),
        .i_wb_stb (i_wb_stb),
        .i_wb_ack (o_wb_ack),
        .i_wb_err (o_wb_err)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    task automatic push_entry(input string name, input bit we, input tag_t tag, input idx_t idx,
                              input ppn_t dat, input bit exp_err, input int way);
        table_q.push_back('{name, we, tag, idx, dat, exp_err, way});
    endtask

    // Walk from the root, 0 picks the lower half
    function automatic int predict_victim();
        int node;
        int way;
        node = 0;
        way  = 0;
        for (int lvl = 0; lvl < 4; lvl++) begin
            way  = 2 * way + int'(plru[node]);
            node = 2 * node + 1 + int'(plru[node]);
        end
        return way;
    endfunction

    task automatic mark_used(input int way);
        int node;
        int half;
        node = 0;
        for (int lvl = 3; lvl >= 0; lvl--) begin
            half       = (way >> lvl) & 1;
            plru[node] = (half == 0);
            node       = 2 * node + 1 + half;
        end
    endtask

    // Classic cycle, stb dropped after the edge that sees the response
    task automatic run_cycle(input entry_t e, output logic ack, output logic err,
                             output ppn_t dat, output int edges);
        @(posedge clk);
        #2;
        i_wb_cyc = 1'b1;
        i_wb_stb = 1'b1;
        i_wb_we  = e.we;
        i_wb_adr = {e.tag, e.idx};
        i_wb_dat = e.we ? e.dat : '0;
        edges    = 0;
        do begin
            @(posedge clk);
            #1;
            edges++;
        end while (!(o_wb_ack || o_wb_err) && edges < TIMEOUT);
        ack = o_wb_ack;
        err = o_wb_err;
        dat = o_wb_dat;
        @(posedge clk);
        #2;
        i_wb_cyc = 1'b0;
        i_wb_stb = 1'b0;
    endtask

    task automatic apply_table();
        logic ack;
        logic err;
        ppn_t dat;
        int   edges;
        foreach (table_q[i]) begin
            run_cycle(table_q[i], ack, err, dat, edges);
            checks++;
            if (!ack && !err) begin
                $display("No ack or err within %0d cycles in %s", TIMEOUT, table_q[i].name);
                errors++;
            end else begin
                if (err !== table_q[i].exp_err || ack !== !table_q[i].exp_err) begin
                    $display("Fail %s: expected err=%0b, actual ack=%0b err=%0b",
                             table_q[i].name, table_q[i].exp_err, ack, err);
                    errors++;
                end
                if (!table_q[i].we && dat !== table_q[i].dat) begin
                    $display("Fail %s: expected data %05h, actual %05h",
                             table_q[i].name, table_q[i].dat, dat);
                    errors++;
                end
                if (edges != 3) begin
                    $display("Fail %s: expected latency 3, actual %0d",
                             table_q[i].name, edges);
                    errors++;
                end
                if (ack && table_q[i].way >= 0) begin
                    mark_used(table_q[i].way);
                end
            end
        end
        table_q.delete();
    endtask

    initial begin
        ppn_t new_dat;
        ppn_t d[4];
        int   victim;
        void'($urandom(56));
        errors   = 0;
        checks   = 0;
        plru     = '0;
        i_rst    = 1'b1;
        i_wb_cyc = 1'b0;
        i_wb_stb = 1'b0;
        i_wb_we  = 1'b0;
        i_wb_adr = '0;
        i_wb_dat = '0;
        repeat (10) @(posedge clk);
        #2;
        i_rst = 1'b0;

        push_entry("cold_miss_a", 0, 20'h12345, 3'd5, '0, 1, -1);
        push_entry("cold_miss_b", 0, 20'hfffff, 3'd7, '0, 1, -1);
        // Empty set fills ways in order
        for (int k = 0; k < 16; k++) begin
            set5_dat[k] = ppn_t'($urandom);
            push_entry($sformatf("fill_set5_%0d", k), 1, tag_t'(32'h100 + k), 3'd5,
                       set5_dat[k], 0, k);
        end
        push_entry("touch_3", 0, 20'h00103, 3'd5, set5_dat[3], 0, 3);
        push_entry("touch_9", 0, 20'h00109, 3'd5, set5_dat[9], 0, 9);
        push_entry("touch_12", 0, 20'h0010c, 3'd5, set5_dat[12], 0, 12);
        apply_table();

        victim  = predict_victim();
        new_dat = ppn_t'($urandom);
        push_entry("fill_evict", 1, 20'h001ff, 3'd5, new_dat, 0, victim);
        for (int k = 0; k < 16; k++) begin
            if (k == victim) begin
                push_entry("evicted_miss", 0, tag_t'(32'h100 + k), 3'd5, '0, 1, -1);
            end else begin
                push_entry($sformatf("kept_%0d", k), 0, tag_t'(32'h100 + k), 3'd5,
                           set5_dat[k], 0, k);
            end
        end
        push_entry("lookup_new", 0, 20'h001ff, 3'd5, new_dat, 0, victim);

        for (int k = 0; k < 4; k++) begin
            d[k] = ppn_t'($urandom);
        end
        push_entry("fill_a_set1", 1, 20'habcde, 3'd1, d[0], 0, 0);
        push_entry("hit_a_set1", 0, 20'habcde, 3'd1, d[0], 0, 0);
        push_entry("fill_b_set1", 1, 20'h00042, 3'd1, d[1], 0, 1);
        push_entry("refill_a_set1", 1, 20'habcde, 3'd1, d[2], 0, 0);
        push_entry("hit_new_a_set1", 0, 20'habcde, 3'd1, d[2], 0, 0);
        push_entry("hit_b_set1", 0, 20'h00042, 3'd1, d[1], 0, 1);
        push_entry("fill_a_set2", 1, 20'habcde, 3'd2, d[3], 0, 0);
        push_entry("hit_a_set2", 0, 20'habcde, 3'd2, d[3], 0, 0);
        push_entry("hit_a_set1_again", 0, 20'habcde, 3'd1, d[2], 0, 0);
        push_entry("miss_b_set2", 0, 20'h00042, 3'd2, '0, 1, -1);
        apply_table();

        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

// File: list.f
+incdir+hdl
hdl/dtlb_pkg.sv
hdl/dtlb_wb_front.sv
hdl/dtlb_entry_array.sv
hdl/dtlb_tag_match.sv
hdl/dtlb_plru_tree.sv
hdl/dtlb_top.sv
testbench/dtlb_chk.sv
testbench/dtlb_tb.sv

// File: run.sh
#!/bin/sh
# Compile and run the DTLB testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert --top-module dtlb_tb -f list.f -o dtlb_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/dtlb_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -qF "FAIL: see errors above" "$LOG"; then
    exit 1
fi
exit 0
